//--- filelist.f
hdl/hazardPkg.sv
hdl/instrDecode.sv
hdl/stageTracker.sv
hdl/regHazardCheck.sv
hdl/memHazardCheck.sv
hdl/hazardControl.sv
hdl/hazardUnit.sv
tests/tbHazardUnit.sv

//--- hdl/hazardControl.sv
`timescale 1ns/1ps

module hazardControl (
    input  logic                 clk,
    input  logic                 rstN,
    input  hazardPkg::instrInfoT info,
    input  logic                 regHazard,
    input  logic                 memHazard,
    output logic                 nop,
    output logic                 pcStall
);
    import hazardPkg::*;

    logic anyHazard;
    logic prevJumpBranch;

    assign anyHazard = regHazard | memHazard;

    // A jump or branch that goes ahead costs one bubble next cycle
    // A stalled one comes back again and is counted then
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prevJumpBranch <= 1'b0;
        end else begin
            prevJumpBranch <= info.isJumpBranch & ~anyHazard;
        end
    end

    // Explicit no-op never stalls or inserts a bubble
    assign nop     = (anyHazard | prevJumpBranch) & ~info.isNop;
    assign pcStall = anyHazard & ~info.isNop;

endmodule

//--- hdl/hazardPkg.sv
package hazardPkg;

    // Instruction format widths
    localparam int regAddrWidth = 3;
    localparam int dataWidth    = 16;
    localparam int opcodeWidth  = 5;

    // Opcodes that the hazard unit decodes on its own
    localparam logic [opcodeWidth-1:0] opNop = 5'b00001;
    localparam logic [opcodeWidth-1:0] opJr  = 5'b00111;

    // Upper three opcode bits select the instruction class
    localparam logic [2:0] jumpClass   = 3'b001;
    localparam logic [2:0] branchClass = 3'b011;

    // Decoded view of the instruction now in fetch
    typedef struct packed {
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic                    isNop;
        logic                    isJumpBranch;
        logic                    isJr;
    } instrInfoT;

    // One instruction as seen by the hazard logic while it is in flight
    typedef struct packed {
        logic [regAddrWidth-1:0] rd;
        logic                    regWrite;
        logic                    memEnable;
        logic [dataWidth-1:0]    memAddr;
    } stageRecT;

    // Records of the four older instructions, youngest first
    typedef struct packed {
        stageRecT id;
        stageRecT ex;
        stageRecT mem;
        stageRecT wb;
    } trackT;

    // Forwarding path enables, bit order matches the forwards output
    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;
        logic memToIdRs;
    } forwardT;

endpackage

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [hazardPkg::dataWidth-1:0]    instr,
    input  logic [hazardPkg::regAddrWidth-1:0] rd,
    input  logic                               regWrite,
    input  logic                               memEnable,
    input  logic [hazardPkg::dataWidth-1:0]    reg1Data,
    input  logic [hazardPkg::dataWidth-1:0]    imm,
    output logic                               nop,
    output logic                               pcStall,
    output hazardPkg::forwardT                 forwards,
    output logic                               isJr
);
    import hazardPkg::*;

    instrInfoT            info;
    trackT                track;
    logic [dataWidth-1:0] memAddr;
    logic                 regHazard;
    logic                 memHazard;

    instrDecode decode0 (
        .instr (instr),
        .info  (info)
    );

    stageTracker tracker0 (
        .clk       (clk),
        .rstN      (rstN),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .memAddr   (memAddr),
        .track     (track)
    );

    regHazardCheck regCheck0 (
        .info      (info),
        .track     (track),
        .forwards  (forwards),
        .regHazard (regHazard)
    );

    memHazardCheck memCheck0 (
        .reg1Data  (reg1Data),
        .imm       (imm),
        .memEnable (memEnable),
        .track     (track),
        .memAddr   (memAddr),
        .memHazard (memHazard)
    );

    hazardControl control0 (
        .clk       (clk),
        .rstN      (rstN),
        .info      (info),
        .regHazard (regHazard),
        .memHazard (memHazard),
        .nop       (nop),
        .pcStall   (pcStall)
    );

    // Passed on for the ID stage
    assign isJr = info.isJr;

endmodule

//--- hdl/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  logic [hazardPkg::dataWidth-1:0] instr,
    output hazardPkg::instrInfoT            info
);
    import hazardPkg::*;

    logic [opcodeWidth-1:0] opcode;
    logic [2:0]             opClass;

    // Opcode sits in the top five bits
    assign opcode  = instr[15:11];
    assign opClass = opcode[opcodeWidth-1:opcodeWidth-3];

    // Source register fields
    assign info.rs = instr[10:8];
    assign info.rt = instr[7:5];

    always_comb begin
        info.isNop        = 1'b0;
        info.isJr         = 1'b0;
        info.isJumpBranch = 1'b0;

        if (opcode == opNop) begin
            info.isNop = 1'b1;
        end

        // Jr is a jump too, so it also gets the bubble
        if (opcode == opJr) begin
            info.isJr = 1'b1;
        end

        case (opClass)
            jumpClass: begin
                info.isJumpBranch = 1'b1;
            end
            branchClass: begin
                info.isJumpBranch = 1'b1;
            end
            default: begin
                info.isJumpBranch = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/memHazardCheck.sv
`timescale 1ns/1ps

module memHazardCheck (
    input  logic [hazardPkg::dataWidth-1:0] reg1Data,
    input  logic [hazardPkg::dataWidth-1:0] imm,
    input  logic                            memEnable,
    input  hazardPkg::trackT                track,
    output logic [hazardPkg::dataWidth-1:0] memAddr,
    output logic                            memHazard
);
    import hazardPkg::*;

    logic idHit;
    logic exHit;
    logic memHit;
    logic wbHit;

    // True when an older access went to the same address
    function automatic logic stageHit(
        input stageRecT             rec,
        input logic [dataWidth-1:0] addr
    );
        logic sameAddr;
        sameAddr = (rec.memAddr == addr);
        return rec.memEnable & sameAddr;
    endfunction

    // Effective address, carry out is dropped
    assign memAddr = reg1Data + imm;

    assign idHit  = stageHit(track.id, memAddr);
    assign exHit  = stageHit(track.ex, memAddr);
    assign memHit = stageHit(track.mem, memAddr);
    assign wbHit  = stageHit(track.wb, memAddr);

    // Only a memory access now can conflict
    always_comb begin
        memHazard = 1'b0;
        if (memEnable) begin
            memHazard = idHit | exHit | memHit | wbHit;
        end
    end

endmodule

//--- hdl/regHazardCheck.sv
`timescale 1ns/1ps

module regHazardCheck (
    input  hazardPkg::instrInfoT info,
    input  hazardPkg::trackT     track,
    output hazardPkg::forwardT   forwards,
    output logic                 regHazard
);
    import hazardPkg::*;

    // Destination matches per stage and source field
    logic idRs;
    logic idRt;
    logic exRs;
    logic exRt;
    logic memRs;
    logic memRt;
    logic wbRs;
    logic wbRt;

    logic rsHazard;
    logic rtHazard;

    assign idRs  = (track.id.rd == info.rs);
    assign idRt  = (track.id.rd == info.rt);
    assign exRs  = (track.ex.rd == info.rs);
    assign exRt  = (track.ex.rd == info.rt);
    assign memRs = (track.mem.rd == info.rs);
    assign memRt = (track.mem.rd == info.rt);
    assign wbRs  = (track.wb.rd == info.rs);
    assign wbRt  = (track.wb.rd == info.rt);

    // A load in ID has no data yet, so the EX to EX path stays shut
    assign forwards.exToExRs  = idRs & ~track.id.memEnable;
    assign forwards.exToExRt  = idRt & ~track.id.memEnable;
    assign forwards.memToExRs = exRs;
    assign forwards.memToExRt = exRt;

    // Paths into ID serve jr and jalr, which read rs early
    assign forwards.exToIdRs  = exRs & ~track.ex.memEnable;
    assign forwards.memToIdRs = memRs;

    always_comb begin
        rsHazard = 1'b0;
        rtHazard = 1'b0;

        // rs against each older stage
        if (idRs & ((track.id.regWrite & ~forwards.exToExRs) | track.id.memEnable)) begin
            rsHazard = 1'b1;
        end
        if (exRs & (track.ex.regWrite | track.ex.memEnable)
                & ~forwards.memToExRs & ~forwards.exToIdRs) begin
            rsHazard = 1'b1;
        end
        if (memRs & track.mem.regWrite & ~forwards.memToIdRs) begin
            rsHazard = 1'b1;
        end
        if (wbRs & track.wb.regWrite) begin
            rsHazard = 1'b1;
        end

        // rt has no path into ID, so mem and wb writers always stall
        if (idRt & ((track.id.regWrite & ~forwards.exToExRt) | track.id.memEnable)) begin
            rtHazard = 1'b1;
        end
        if (exRt & track.ex.regWrite & ~forwards.memToExRt) begin
            rtHazard = 1'b1;
        end
        if (memRt & track.mem.regWrite) begin
            rtHazard = 1'b1;
        end
        if (wbRt & track.wb.regWrite) begin
            rtHazard = 1'b1;
        end
    end

    assign regHazard = rsHazard | rtHazard;

endmodule

//--- hdl/stageTracker.sv
`timescale 1ns/1ps

module stageTracker (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [hazardPkg::regAddrWidth-1:0] rd,
    input  logic                               regWrite,
    input  logic                               memEnable,
    input  logic [hazardPkg::dataWidth-1:0]    memAddr,
    output hazardPkg::trackT                   track
);
    import hazardPkg::*;

    stageRecT newRec;
    trackT    trackQ;

    // Record of the instruction presented this cycle
    always_comb begin
        newRec           = '0;
        newRec.rd        = rd;
        newRec.regWrite  = regWrite;
        newRec.memEnable = memEnable;
        newRec.memAddr   = memAddr;
    end

    // Shadow pipeline, advances every clock
    // Fetch supplies a bubble record while the unit stalls it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            trackQ <= '0;
        end else begin
            trackQ.wb  <= trackQ.mem;
            trackQ.mem <= trackQ.ex;
            trackQ.ex  <= trackQ.id;
            trackQ.id  <= newRec;
        end
    end

    assign track = trackQ;

endmodule

//--- runSim.sh
#!/bin/sh
# Build and run the hazard unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing \
    --top-module tbHazardUnit \
    -Mdir obj_dir \
    -f filelist.f

./obj_dir/VtbHazardUnit | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- tests/tbHazardUnit.sv
`timescale 1ns/1ps

module tbHazardUnit;
    import hazardPkg::*;

    localparam int numCycles  = 3000;
    localparam int resetTicks = 4;

    logic        clk;
    logic        rstN;
    logic [15:0] instr;
    logic [2:0]  rd;
    logic        regWrite;
    logic        memEnable;
    logic [15:0] reg1Data;
    logic [15:0] imm;
    logic        nop;
    logic        pcStall;
    forwardT     fwdOut;
    logic        isJr;

    // Reference model state with index 0 as ID and 3 as WB
    logic [2:0]  mRd[4];
    logic        mRw[4];
    logic        mMe[4];
    logic [15:0] mAddr[4];
    logic        prevJb;

    // Expected values for the cycle now presented
    logic [5:0]  expFwd;
    logic        expRegHaz;
    logic        expMemHaz;
    logic        expNop;
    logic        expStall;
    logic        expJr;
    logic        expJb;
    logic        expIsNop;
    logic [15:0] expAddr;

    logic [31:0] rngState;
    int          errors;
    int          checks;
    int          seenRegStall;
    int          seenMemStall;
    int          seenBubble;
    int          seenNopMask;
    int          seenJr;

    hazardUnit dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .reg1Data  (reg1Data),
        .imm       (imm),
        .nop       (nop),
        .pcStall   (pcStall),
        .forwards  (fwdOut),
        .isJr      (isJr)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Opcode mix leans on NOP, jr, jump and branch; small register and address ranges
    task automatic driveRandom;
        logic [31:0] r;
        logic [4:0]  op;
        rngState = xorshift32(rngState);
        r = rngState;
        case (r[2:0])
            3'd0: op = 5'b00001;
            3'd1: op = 5'b00111;
            3'd2: op = {3'b001, r[4:3]};
            3'd3: op = {3'b011, r[4:3]};
            default: op = r[7:3];
        endcase
        instr     = {op, r[10:8], r[13:11], r[18:14]};
        rd        = r[21:19];
        regWrite  = r[22];
        memEnable = r[23] & r[24];
        reg1Data  = {14'd0, r[26:25]};
        imm       = {14'd0, r[28:27]};
    endtask

    task automatic computeExpected;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [4:0] op;
        logic       fExExRs;
        logic       fMemExRs;
        logic       fExExRt;
        logic       fMemExRt;
        logic       fExIdRs;
        logic       fMemIdRs;
        op       = instr[15:11];
        rs       = instr[10:8];
        rt       = instr[7:5];
        expIsNop = (op == 5'b00001);
        expJr    = (op == 5'b00111);
        expJb    = (op[4:2] == 3'b001) || (op[4:2] == 3'b011);

        fExExRs  = (mRd[0] == rs) && !mMe[0];
        fExExRt  = (mRd[0] == rt) && !mMe[0];
        fMemExRs = (mRd[1] == rs);
        fMemExRt = (mRd[1] == rt);
        fExIdRs  = (mRd[1] == rs) && !mMe[1];
        fMemIdRs = (mRd[2] == rs);
        expFwd   = {fExExRs, fMemExRs, fExExRt, fMemExRt, fExIdRs, fMemIdRs};

        expRegHaz = 1'b0;
        if ((mRd[0] == rs) && ((mRw[0] && !fExExRs) || mMe[0])) expRegHaz = 1'b1;
        if ((mRd[1] == rs) && (mRw[1] || mMe[1]) && !fMemExRs && !fExIdRs) expRegHaz = 1'b1;
        if ((mRd[2] == rs) && mRw[2] && !fMemIdRs) expRegHaz = 1'b1;
        if ((mRd[3] == rs) && mRw[3]) expRegHaz = 1'b1;
        if ((mRd[0] == rt) && ((mRw[0] && !fExExRt) || mMe[0])) expRegHaz = 1'b1;
        if ((mRd[1] == rt) && mRw[1] && !fMemExRt) expRegHaz = 1'b1;
        if ((mRd[2] == rt) && mRw[2]) expRegHaz = 1'b1;
        if ((mRd[3] == rt) && mRw[3]) expRegHaz = 1'b1;

        expAddr   = reg1Data + imm;
        expMemHaz = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (memEnable && mMe[i] && (mAddr[i] == expAddr)) expMemHaz = 1'b1;
        end

        expStall = (expRegHaz || expMemHaz) && !expIsNop;
        expNop   = (expRegHaz || expMemHaz || prevJb) && !expIsNop;
    endtask

    task automatic compareOutputs;
        checks++;
        if (fwdOut !== expFwd) begin
            $display("ERR %0t: forwards got %b expected %b", $time, fwdOut, expFwd);
            errors++;
        end
        if (pcStall !== expStall) begin
            $display("ERR %0t: pcStall got %b expected %b", $time, pcStall, expStall);
            errors++;
        end
        if (nop !== expNop) begin
            $display("ERR %0t: nop got %b expected %b", $time, nop, expNop);
            errors++;
        end
        if (isJr !== expJr) begin
            $display("ERR %0t: isJr got %b expected %b", $time, isJr, expJr);
            errors++;
        end
        if (expStall && expRegHaz) seenRegStall++;
        if (expStall && expMemHaz) seenMemStall++;
        if (prevJb && expNop && !expStall) seenBubble++;
        if (expIsNop && (expRegHaz || expMemHaz)) seenNopMask++;
        if (expJr) seenJr++;
    endtask

    // Records and bubble flag as they come out of reset
    task automatic clearModel;
        prevJb = 1'b0;
        for (int i = 0; i < 4; i++) begin
            mRd[i]   = '0;
            mRw[i]   = 1'b0;
            mMe[i]   = 1'b0;
            mAddr[i] = '0;
        end
    endtask

    // Shift mirrors the shadow pipeline on each rising edge
    task automatic advanceModel;
        for (int i = 3; i > 0; i--) begin
            mRd[i]   = mRd[i-1];
            mRw[i]   = mRw[i-1];
            mMe[i]   = mMe[i-1];
            mAddr[i] = mAddr[i-1];
        end
        mRd[0]   = rd;
        mRw[0]   = regWrite;
        mMe[0]   = memEnable;
        mAddr[0] = expAddr;
        prevJb   = expJb && !expRegHaz && !expMemHaz;
    endtask

    // Reset in the middle of traffic must clear every record at once
    task automatic resetMidRun;
        rstN = 1'b0;
        clearModel();
        for (int k = 0; k < resetTicks; k++) begin
            driveRandom();
            #2;
            computeExpected();
            compareOutputs();
            if (pcStall !== 1'b0) begin
                $display("ERR %0t: pcStall high while in reset", $time);
                errors++;
            end
            @(negedge clk);
        end
    endtask

    // Watchdog bounds the whole run
    initial begin
        int ticks;
        ticks = 0;
        while (ticks < (numCycles + 100) * 10) begin
            #1;
            ticks++;
        end
        $display("Simulation did not finish within its cycle budget");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int resetCount;
        clk       = 1'b0;
        rstN      = 1'b0;
        instr     = '0;
        rd        = '0;
        regWrite  = 1'b0;
        memEnable = 1'b0;
        reg1Data  = '0;
        imm       = '0;
        rngState  = 32'he4d1_930b;
        errors    = 0;
        checks    = 0;
        seenRegStall = 0;
        seenMemStall = 0;
        seenBubble   = 0;
        seenNopMask  = 0;
        seenJr       = 0;
        clearModel();

        resetCount = 0;
        while (resetCount < resetTicks) begin
            @(posedge clk);
            resetCount++;
        end

        for (int cyc = 0; cyc < numCycles; cyc++) begin
            @(negedge clk);
            if (cyc == numCycles / 2) begin
                resetMidRun();
            end
            rstN = 1'b1;
            driveRandom();
            #2;
            computeExpected();
            compareOutputs();
            // Nothing has entered the tracker yet
            if (cyc == 0 && pcStall !== 1'b0) begin
                $display("ERR %0t: pcStall high right after reset", $time);
                errors++;
            end
            @(posedge clk);
            advanceModel();
        end

        if (seenRegStall == 0) begin
            $display("Random stimulus never produced a register stall");
            errors++;
        end
        if (seenMemStall == 0) begin
            $display("Random stimulus never produced a memory stall");
            errors++;
        end
        if (seenBubble == 0) begin
            $display("Random stimulus never produced a branch bubble");
            errors++;
        end
        if (seenNopMask == 0) begin
            $display("Random stimulus never masked a hazard with an explicit no-op");
            errors++;
        end
        if (seenJr == 0) begin
            $display("Random stimulus never presented a jr opcode");
            errors++;
        end

        $display("Cycles checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
